// ==== rtl/hazard_defines.svh ====
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

// Instruction field positions, fixed by the ISA
`define OPC_HI   15
`define OPC_LO   12
`define RA_HI    11
`define RA_LO    9
`define RB_HI    8
`define RB_LO    6
`define RC_HI    5
`define RC_LO    3

// Opcodes
`define OP_ADD   4'b0000 // R-type add
`define OP_NDU   4'b0010 // R-type nand
`define OP_ADI   4'b0001
`define OP_LHI   4'b0011
`define OP_LW    4'b0100
`define OP_SW    4'b0101
`define OP_BEQ   4'b1100 // Compares ra and rb like an ALU op
`define OP_JAL   4'b1000
`define OP_JLR   4'b1001

// ALU operand and store-data mux selects
`define SEL_REG  2'd0 // Register file value
`define SEL_MEM  2'd1 // Forwarded from memory stage
`define SEL_IMM  2'd3 // Immediate operand

// Which memory-stage value gets forwarded
`define MSRC_ALU 2'd0 // ALU result
`define MSRC_PC1 2'd1 // Link value of JAL/JLR
`define MSRC_LHI 2'd2 // Zero-padded LHI immediate

`endif

// ==== rtl/hazard_pkg.sv ====
`include "hazard_defines.svh"

package hazard_pkg;

	// Opcode occupies the top bits, so the word ends at OPC_HI
	typedef logic [`OPC_HI:0] instr_t;

	typedef logic [`OPC_HI-`OPC_LO:0] opcode_t; // Opcode field

	typedef logic [`RA_HI-`RA_LO:0] reg_idx_t; // One of eight registers

	// Shared by op1, op2, store-data and memory-source selects
	typedef logic [1:0] fwd_sel_t;

endpackage

// ==== rtl/hazard_ifs.sv ====
`timescale 1ns/100ps

// Register reads of the execute-stage instruction
interface operand_use_if import hazard_pkg::*; ();
	reg_idx_t op1_reg;   // Register feeding ALU operand 1
	logic     op1_used;
	reg_idx_t op2_reg;   // Register feeding ALU operand 2
	logic     op2_used;
	reg_idx_t data_reg;  // Store data or jump target
	logic     data_used;
	logic     op2_imm;   // Operand 2 comes from the immediate

	modport producer (
		output op1_reg, op1_used, op2_reg, op2_used, data_reg, data_used, op2_imm
	);
	modport consumer (
		input op1_reg, op1_used, op2_reg, op2_used, data_reg, data_used, op2_imm
	);
endinterface

// Register write of the memory-stage instruction
interface result_source_if import hazard_pkg::*; ();
	reg_idx_t dest_reg;
	logic     dest_valid; // Instruction writes a register
	logic     is_load;    // Value not ready until after memory
	fwd_sel_t mem_src;    // Which memory-stage value holds the result

	modport producer (
		output dest_reg, dest_valid, is_load, mem_src
	);
	modport consumer (
		input dest_reg, dest_valid, is_load, mem_src
	);
endinterface

// ==== rtl/operand_use_decode.sv ====
`timescale 1ns/100ps
`include "hazard_defines.svh"

module operand_use_decode import hazard_pkg::*;
(
	input  instr_t          ins_current,
	operand_use_if.producer use_out
);

	opcode_t  opcode;
	reg_idx_t ra;
	reg_idx_t rb;

	assign opcode = ins_current[`OPC_HI:`OPC_LO];
	assign ra     = ins_current[`RA_HI:`RA_LO];
	assign rb     = ins_current[`RB_HI:`RB_LO];

	always_comb
	begin
		use_out.op1_reg   = '0;
		use_out.op1_used  = 1'b0;
		use_out.op2_reg   = '0;
		use_out.op2_used  = 1'b0;
		use_out.data_reg  = '0;
		use_out.data_used = 1'b0;
		use_out.op2_imm   = 1'b0;

		case (opcode)
			`OP_ADD, `OP_NDU, `OP_BEQ:
			begin
				use_out.op1_reg  = ra;
				use_out.op1_used = 1'b1;
				use_out.op2_reg  = rb; // Second source, no immediate
				use_out.op2_used = 1'b1;
			end

			`OP_ADI:
			begin
				use_out.op1_reg  = ra;
				use_out.op1_used = 1'b1;
				use_out.op2_imm  = 1'b1;
			end

			`OP_LW:
			begin
				use_out.op1_reg  = rb; // Base address
				use_out.op1_used = 1'b1;
				use_out.op2_imm  = 1'b1; // Offset
			end

			`OP_SW:
			begin
				use_out.op1_reg   = rb; // Base address
				use_out.op1_used  = 1'b1;
				use_out.data_reg  = ra; // Value to store
				use_out.data_used = 1'b1;
				use_out.op2_imm   = 1'b1;
			end

			`OP_JLR:
			begin
				// Jump target goes through the data path, not the ALU
				use_out.data_reg  = rb;
				use_out.data_used = 1'b1;
			end

			default:
			begin
				use_out.op2_imm = 1'b0; // LHI, JAL and unknown read nothing
			end
		endcase
	end

endmodule

// ==== rtl/result_source_decode.sv ====
`timescale 1ns/100ps
`include "hazard_defines.svh"

module result_source_decode import hazard_pkg::*;
(
	input  instr_t            ins_prev,
	result_source_if.producer res_out
);

	opcode_t opcode;

	assign opcode = ins_prev[`OPC_HI:`OPC_LO];

	always_comb
	begin
		res_out.dest_reg   = '0;
		res_out.dest_valid = 1'b0;
		res_out.is_load    = 1'b0;
		res_out.mem_src    = `MSRC_ALU;

		case (opcode)
			`OP_ADD, `OP_NDU:
			begin
				res_out.dest_reg   = ins_prev[`RC_HI:`RC_LO];
				res_out.dest_valid = 1'b1;
			end

			`OP_ADI:
			begin
				res_out.dest_reg   = ins_prev[`RB_HI:`RB_LO]; // ADI writes rb
				res_out.dest_valid = 1'b1;
			end

			`OP_LHI:
			begin
				res_out.dest_reg   = ins_prev[`RA_HI:`RA_LO];
				res_out.dest_valid = 1'b1;
				res_out.mem_src    = `MSRC_LHI;
			end

			`OP_JAL, `OP_JLR:
			begin
				res_out.dest_reg   = ins_prev[`RA_HI:`RA_LO];
				res_out.dest_valid = 1'b1;
				res_out.mem_src    = `MSRC_PC1; // Return address
			end

			`OP_LW:
			begin
				res_out.dest_reg   = ins_prev[`RA_HI:`RA_LO];
				res_out.dest_valid = 1'b1;
				res_out.is_load    = 1'b1; // Data arrives a stage later
			end

			default:
			begin
				res_out.dest_valid = 1'b0; // No register written
			end
		endcase
	end

endmodule

// ==== rtl/forward_select.sv ====
`timescale 1ns/100ps
`include "hazard_defines.svh"

module forward_select import hazard_pkg::*;
(
	operand_use_if.consumer   use_in,
	result_source_if.consumer res_in,
	output fwd_sel_t          op1_sel,
	output fwd_sel_t          op2_sel,
	output fwd_sel_t          d2_sel,
	output fwd_sel_t          mem_src_sel,
	output logic              hazard_detect,
	output logic              stall
);

	logic op1_hit;
	logic op2_hit;
	logic data_hit;
	logic any_hit;

	// A read depends on the memory stage only if both sides are real
	assign op1_hit  = res_in.dest_valid && use_in.op1_used &&
		(use_in.op1_reg == res_in.dest_reg);
	assign op2_hit  = res_in.dest_valid && use_in.op2_used &&
		(use_in.op2_reg == res_in.dest_reg);
	assign data_hit = res_in.dest_valid && use_in.data_used &&
		(use_in.data_reg == res_in.dest_reg);

	assign any_hit = op1_hit | op2_hit | data_hit;

	always_comb
	begin
		op1_sel       = `SEL_REG;
		op2_sel       = `SEL_REG;
		d2_sel        = `SEL_REG;
		mem_src_sel   = `MSRC_ALU;
		stall         = 1'b0;
		hazard_detect = any_hit;

		if (any_hit && res_in.is_load)
		begin
			// Load data not ready yet so the pipe holds
			stall = 1'b1;
		end
		else if (any_hit)
		begin
			mem_src_sel = res_in.mem_src;

			if (use_in.op2_imm)
			begin
				op2_sel = `SEL_IMM;
			end

			// Only one select is forwarded with op1 first
			if (op1_hit)
			begin
				op1_sel = `SEL_MEM;
			end
			else if (op2_hit)
			begin
				op2_sel = `SEL_MEM;
			end
			else
			begin
				d2_sel = `SEL_MEM; // Store data or jump target
			end
		end
	end

endmodule

// ==== rtl/hazard_forward_unit.sv ====
`timescale 1ns/100ps

module hazard_forward_unit import hazard_pkg::*;
(
	input  instr_t   ins_current,   // Execute-stage instruction
	input  instr_t   ins_prev,      // Memory-stage instruction
	output fwd_sel_t op1_sel,
	output fwd_sel_t op2_sel,
	output fwd_sel_t d2_sel,
	output fwd_sel_t mem_src_sel,
	output logic     hazard_detect,
	output logic     stall
);

	operand_use_if   use_bus ();
	result_source_if res_bus ();

	// Reads of the consumer
	operand_use_decode i_operand_use_decode
	(
		.ins_current (ins_current),
		.use_out     (use_bus)
	);

	// Write of the producer
	result_source_decode i_result_source_decode
	(
		.ins_prev (ins_prev),
		.res_out  (res_bus)
	);

	forward_select i_forward_select
	(
		.use_in        (use_bus),
		.res_in        (res_bus),
		.op1_sel       (op1_sel),
		.op2_sel       (op2_sel),
		.d2_sel        (d2_sel),
		.mem_src_sel   (mem_src_sel),
		.hazard_detect (hazard_detect),
		.stall         (stall)
	);

endmodule

// ==== testbench/tb_forward_model.svh ====
`ifndef TB_FORWARD_MODEL_SVH
`define TB_FORWARD_MODEL_SVH

// Expected outputs packed as {op1, op2, d2, mem_src, hazard_detect, stall}
function automatic logic [9:0] expected_outputs(input instr_t cur, input instr_t prev);
	reg_idx_t read1, read2, read3; // op1, op2 and data registers
	logic     use1, use2, use3;
	logic     imm;
	reg_idx_t dest;
	logic     writes;
	logic     load;
	fwd_sel_t src;
	logic [1:0] slot;              // 0 none, 1 op1, 2 op2, 3 data
	fwd_sel_t e_op1, e_op2, e_d2, e_src;
	logic     e_hd, e_stall;

	{read1, read2, read3} = '0;
	{use1, use2, use3, imm} = '0;
	{dest, writes, load} = '0;
	src = `MSRC_ALU;

	case (cur[15:12]) // Reads of the execute-stage word
		`OP_ADD, `OP_NDU, `OP_BEQ:
		begin
			read1 = cur[11:9];
			use1  = 1'b1;
			read2 = cur[8:6];
			use2  = 1'b1;
		end
		`OP_ADI:
		begin
			read1 = cur[11:9];
			use1  = 1'b1;
			imm   = 1'b1;
		end
		`OP_LW:
		begin
			read1 = cur[8:6];
			use1  = 1'b1;
			imm   = 1'b1;
		end
		`OP_SW:
		begin
			read1 = cur[8:6];
			use1  = 1'b1;
			read3 = cur[11:9];
			use3  = 1'b1;
			imm   = 1'b1;
		end
		`OP_JLR:
		begin
			read3 = cur[8:6];
			use3  = 1'b1;
		end
		default:
		begin
			imm = 1'b0;
		end
	endcase

	case (prev[15:12]) // Write of the memory-stage word
		`OP_ADD, `OP_NDU:
		begin
			dest   = prev[5:3];
			writes = 1'b1;
		end
		`OP_ADI:
		begin
			dest   = prev[8:6];
			writes = 1'b1;
		end
		`OP_LHI:
		begin
			dest   = prev[11:9];
			writes = 1'b1;
			src    = `MSRC_LHI;
		end
		`OP_JAL, `OP_JLR:
		begin
			dest   = prev[11:9];
			writes = 1'b1;
			src    = `MSRC_PC1;
		end
		`OP_LW:
		begin
			dest   = prev[11:9];
			writes = 1'b1;
			load   = 1'b1;
		end
		default:
		begin
			writes = 1'b0;
		end
	endcase

	slot = 2'd0;
	if (writes && use1 && read1 == dest)
	begin
		slot = 2'd1;
	end
	else if (writes && use2 && read2 == dest)
	begin
		slot = 2'd2;
	end
	else if (writes && use3 && read3 == dest)
	begin
		slot = 2'd3;
	end

	{e_op1, e_op2, e_d2, e_src, e_hd, e_stall} = '0;
	if (slot != 2'd0)
	begin
		e_hd = 1'b1;
		if (load)
		begin
			e_stall = 1'b1; // Load-use leaves every select at zero
		end
		else
		begin
			e_src = src;
			if (imm)
			begin
				e_op2 = `SEL_IMM;
			end
			case (slot)
				2'd1:    e_op1 = `SEL_MEM;
				2'd2:    e_op2 = `SEL_MEM;
				default: e_d2  = `SEL_MEM;
			endcase
		end
	end

	return {e_op1, e_op2, e_d2, e_src, e_hd, e_stall};
endfunction

`endif

// ==== testbench/tb_hazard_forward_unit.sv ====
`timescale 1ns/100ps
`include "hazard_defines.svh"

module tb_hazard_forward_unit import hazard_pkg::*; ();

	localparam int NUM_VECTORS    = 2000;
	localparam int RESET_CYCLES   = 5;
	localparam int TIMEOUT_CYCLES = NUM_VECTORS + 100; // Vectors, reset and some slack

	logic        clk;
	logic        rst_n;
	instr_t      ins_current;
	instr_t      ins_prev;
	fwd_sel_t    op1_sel;
	fwd_sel_t    op2_sel;
	fwd_sel_t    d2_sel;
	fwd_sel_t    mem_src_sel;
	logic        hazard_detect;
	logic        stall;
	logic [31:0] rng_state;
	int          error_count   = 0;
	int          forward_count = 0;
	int          stall_count   = 0;
	int          cycle_count   = 0;

	`include "tb_forward_model.svh"

	hazard_forward_unit i_hazard_forward_unit
	(
		.ins_current   (ins_current),
		.ins_prev      (ins_prev),
		.op1_sel       (op1_sel),
		.op2_sel       (op2_sel),
		.d2_sel        (d2_sel),
		.mem_src_sel   (mem_src_sel),
		.hazard_detect (hazard_detect),
		.stall         (stall)
	);

	always #50 clk = ~clk; // 100 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Mostly listed opcodes and some raw 4-bit values
	function automatic opcode_t pick_opcode(input logic [7:0] r);
		case (r[3:0])
			4'd0:    return `OP_ADD;
			4'd1:    return `OP_NDU;
			4'd2:    return `OP_ADI;
			4'd3:    return `OP_LHI;
			4'd4:    return `OP_LW;
			4'd5:    return `OP_SW;
			4'd6:    return `OP_BEQ;
			4'd7:    return `OP_JAL;
			4'd8:    return `OP_JLR;
			default: return r[7:4];
		endcase
	endfunction

	// Mostly registers 0 to 3 so that fields collide often
	function automatic reg_idx_t narrow_reg(input logic [3:0] r);
		return {r[3] & r[2], r[1:0]};
	endfunction

	function automatic instr_t random_instr(input logic [31:0] r);
		return {pick_opcode(r[7:0]), narrow_reg(r[11:8]), narrow_reg(r[15:12]),
			narrow_reg(r[19:16]), r[22:20]};
	endfunction

	task automatic compare_field(input string name, input logic [1:0] actual,
		input logic [1:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h (cur 0x%04h, prev 0x%04h)",
				name, actual, expected, ins_current, ins_prev);
			error_count++;
		end
	endtask

	task automatic check_outputs();
		logic [9:0] exp_out;
		exp_out = expected_outputs(ins_current, ins_prev);
		compare_field("op1_sel", op1_sel, exp_out[9:8]);
		compare_field("op2_sel", op2_sel, exp_out[7:6]);
		compare_field("d2_sel", d2_sel, exp_out[5:4]);
		compare_field("mem_src_sel", mem_src_sel, exp_out[3:2]);
		compare_field("hazard_detect", {1'b0, hazard_detect}, {1'b0, exp_out[1]});
		compare_field("stall", {1'b0, stall}, {1'b0, exp_out[0]});
		if (exp_out[0])
		begin
			stall_count++;
		end
		else if (exp_out[1])
		begin
			forward_count++;
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		ins_current = '0;
		ins_prev    = '0;
		rng_state   = 32'd77429;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int n = 0; n < NUM_VECTORS; n++)
		begin
			rng_state   = xorshift32(rng_state);
			ins_current = random_instr(rng_state);
			rng_state   = xorshift32(rng_state);
			ins_prev    = random_instr(rng_state);
			@(posedge clk); // Outputs settled since the falling edge
			check_outputs();
			@(negedge clk);
		end

		if (forward_count == 0 || stall_count == 0)
		begin
			$display("Stimulus never produced both a forward and a load-use stall");
			error_count++;
		end

		$display("Vectors %0d, forwards %0d, stalls %0d, errors %0d",
			NUM_VECTORS, forward_count, stall_count, error_count);
		if (error_count == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+rtl
+incdir+testbench
rtl/hazard_pkg.sv
rtl/hazard_ifs.sv
rtl/operand_use_decode.sv
rtl/result_source_decode.sv
rtl/forward_select.sv
rtl/hazard_forward_unit.sv
testbench/tb_hazard_forward_unit.sv

// ==== run_sim.sh ====
#!/bin/bash
# Compile with Verilator, run, and judge the result from run.log
cd "$(dirname "$0")" &&
rm -f run.log &&
verilator --binary --timing -f sim.f --top-module tb_hazard_forward_unit \
	-o tb_sim > run.log 2>&1 &&
./obj_dir/tb_sim >> run.log 2>&1
grep -qx "SIMULATION PASSED" run.log && echo "Result: pass" ||
	{ echo "Result: fail, see run.log"; exit 1; }
